// File: sim.f
source/shtp_pkg.sv
source/byte_xfer_if.sv
source/shtp_pkt_if.sv
source/shtp_cmd_rom.sv
source/spi_byte_link.sv
source/shtp_framer.sv
source/report_decoder.sv
source/shtp_sequencer.sv
source/bno085_hub.sv
testbench/sensor_model.sv
testbench/tb_bno085_hub.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_bno085_hub -f sim.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_bno085_hub.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bno085_hub
    import shtp_pkg::*;
();
    localparam int POWERUP = 20, WAKE = 4, INT_TO = 60, RESP_TO = 300, GAP = 8;
    localparam int NUM_ROT = 6, NUM_GYRO = 6, NUM_BAD = 6;
    localparam int BYTE_CYC = 12; // Worst case cycles per SPI byte
    localparam int INIT_CYC = POWERUP + 3 * (WAKE + 22 * BYTE_CYC + GAP + 20);
    localparam int DATA_CYC = (NUM_ROT + NUM_GYRO + NUM_BAD + 1) * (18 * BYTE_CYC + 10);
    localparam int LIMIT    = 2 * (INIT_CYC + DATA_CYC + POWERUP + WAKE + INT_TO + 50);

    logic    clk = 1'b0, rst_n = 1'b0, respond = 1'b1;
    logic    spi_start, spi_tx_valid, spi_rx_valid, spi_busy, cs_n, ps0_wake, int_n;
    byte_t   spi_tx_data, spi_rx_data;
    logic    quat_valid, gyro_valid, initialized, error;
    sample_t quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z;

    int      errors = 0, checks = 0, cycles = 0;
    quat_t   quat_exp[$];
    vec3_t   gyro_exp[$];
    quat_t   last_quat = '0;
    byte_t   pkt_buf[$];

    bno085_hub #(
        .POWERUP_CYCLES (POWERUP), .WAKE_CYCLES (WAKE), .INT_TIMEOUT (INT_TO),
        .RESP_TIMEOUT (RESP_TO), .CMD_GAP_CYCLES (GAP)
    ) UUT (.*);

    sensor_model model (.*);

    initial forever #2 clk = ~clk; // 4 ns period

    // ==============================
    // Reference and check helpers
    // ==============================
    function automatic byte_t exp_cmd_byte(input int cmd, input int idx);
        logic [31:0] iv;
        iv = REPORT_INTERVAL_US >> (8 * (idx - 9));
        case (idx)
            0: return (cmd == 0) ? 8'd5 : 8'd17;
            1: return 8'h00;
            2: return CH_CONTROL;
            3: return 8'(cmd);                // Sequence follows command order
            4: return (cmd == 0) ? RID_PROD_ID_REQ : RID_SET_FEATURE;
            5: return (cmd == 1) ? RID_ROT_VEC : RID_GYRO;
            9, 10, 11, 12: return iv[7:0];
            default: return 8'h00;
        endcase
    endfunction

    function automatic sample_t le16(input byte_t lo, input byte_t hi);
        return {hi, lo};
    endfunction

    task automatic compare_value(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic check_quiet_outputs(input string name);
        compare_value({name, "_cs_n"}, 1, int'(cs_n));
        compare_value({name, "_ps0_wake"}, 1, int'(ps0_wake));
        compare_value({name, "_valids"}, 0, int'(quat_valid | gyro_valid));
        compare_value({name, "_spi_start"}, 0, int'(spi_start | spi_tx_valid));
        compare_value({name, "_init_err"}, 0, int'(initialized | error));
    endtask

    // Builds a report around 8 random field bytes and queues it
    // Kind 1 expects a quaternion and kind 2 a gyro sample
    task automatic send_report(input byte_t chan, input byte_t rid, input int n_pay,
                               input int kind);
        byte_t f[8];
        quat_t q;
        vec3_t g;
        for (int i = 0; i < 8; i++) f[i] = byte_t'($urandom);
        pkt_buf = {byte_t'(n_pay + 4), 8'h00, chan, 8'h00, rid, 8'h01, 8'h03, 8'h00};
        for (int i = 0; i < 8; i++) pkt_buf.push_back(f[i]);
        pkt_buf.push_back(8'h00);        // Accuracy estimate
        pkt_buf.push_back(8'h00);
        while (pkt_buf.size() > n_pay + 4) void'(pkt_buf.pop_back());
        q = '{w: le16(f[6], f[7]), x: le16(f[0], f[1]), y: le16(f[2], f[3]),
              z: le16(f[4], f[5])};
        g = '{x: le16(f[0], f[1]), y: le16(f[2], f[3]), z: le16(f[4], f[5])};
        if (kind == 1) quat_exp.push_back(q);
        if (kind == 2) gyro_exp.push_back(g);
        queue_packet();
    endtask

    task automatic queue_packet();
        foreach (pkt_buf[i]) model.out_bytes.push_back(pkt_buf[i]);
        model.out_lens.push_back(pkt_buf.size()); // Length goes in last as INT follows it
    endtask

    task automatic drain_reads();
        while (model.out_lens.size() != 0 || !cs_n || quat_exp.size() != 0
               || gyro_exp.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    // ==============================
    // Compare process
    // ==============================
    always @(negedge clk) begin
        quat_t e;
        vec3_t g;
        if (quat_valid) begin
            if (quat_exp.size() == 0) begin
                errors++;
                $display("quat_valid pulsed with no rotation report pending");
            end else begin
                e = quat_exp.pop_front();
                compare_value("quat_w", int'(e.w), int'(quat_w));
                compare_value("quat_x", int'(e.x), int'(quat_x));
                compare_value("quat_y", int'(e.y), int'(quat_y));
                compare_value("quat_z", int'(e.z), int'(quat_z));
                last_quat = e;
            end
        end
        if (gyro_valid) begin
            if (gyro_exp.size() == 0) begin
                errors++;
                $display("gyro_valid pulsed with no gyroscope report pending");
            end else begin
                g = gyro_exp.pop_front();
                compare_value("gyro_x", int'(g.x), int'(gyro_x));
                compare_value("gyro_y", int'(g.y), int'(gyro_y));
                compare_value("gyro_z", int'(g.z), int'(gyro_z));
                compare_value("quat_hold_w", int'(last_quat.w), int'(quat_w));
                compare_value("quat_hold_x", int'(last_quat.x), int'(quat_x));
                compare_value("quat_hold_y", int'(last_quat.y), int'(quat_y));
                compare_value("quat_hold_z", int'(last_quat.z), int'(quat_z));
            end
        end
    end

    // Cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Run stopped at the cycle limit, DUT did not finish in time");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ==============================
    // Tests
    // ==============================
    initial begin
        int base;
        void'($urandom(32'ha09e));
        @(negedge clk);
        check_quiet_outputs("reset");
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_quiet_outputs("after_reset");

        // Init sequence with three answered commands
        while (!initialized) @(negedge clk);
        compare_value("init_error", 0, int'(error));
        compare_value("resp_count", 3, model.resp_sent);
        if (model.cmd_lens.size() != 3) begin
            errors++;
            $display("Sensor saw %0d command packets instead of 3", model.cmd_lens.size());
        end else begin
            base = 0;
            for (int c = 0; c < 3; c++) begin
                compare_value($sformatf("cmd%0d_len", c), int'(exp_cmd_byte(c, 0)),
                              model.cmd_lens[c]);
                for (int i = 0; i < model.cmd_lens[c]; i++)
                    compare_value($sformatf("cmd%0d_byte%0d", c, i),
                                  int'(exp_cmd_byte(c, i)), int'(model.cmd_bytes[base + i]));
                base += model.cmd_lens[c];
            end
        end

        for (int i = 0; i < NUM_ROT; i++) send_report(CH_REPORTS, RID_ROT_VEC, 14, 1);
        drain_reads();
        for (int i = 0; i < NUM_GYRO; i++) send_report(CH_GYRO_RV, RID_GYRO, 10, 2);
        drain_reads();

        // Packets that must not decode
        send_report(8'd1, RID_ROT_VEC, 14, 0);   // Wrong channel
        send_report(CH_REPORTS, 8'h07, 14, 0);   // Unknown report ID
        send_report(CH_REPORTS, RID_ROT_VEC, 9, 0); // Ends inside the fields
        send_report(CH_GYRO_RV, RID_GYRO, 8, 0);
        pkt_buf = {8'd2, 8'h00, CH_REPORTS, 8'h00}; // Length below the header
        queue_packet();
        pkt_buf = {8'hFF, 8'hFF, CH_REPORTS, 8'h00}; // Length above the maximum
        queue_packet();
        send_report(CH_REPORTS, RID_ROT_VEC, 14, 1);
        drain_reads();
        compare_value("error_in_data", 0, int'(error));
        compare_value("init_held", 1, int'(initialized));

        // Silent sensor after a fresh reset
        @(posedge clk);
        respond <= 1'b0;
        rst_n   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (!error) @(negedge clk);
        repeat (2) @(negedge clk);
        compare_value("timeout_error_held", 1, int'(error));
        compare_value("timeout_init", 0, int'(initialized));
        compare_value("timeout_cs_n", 1, int'(cs_n));

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/sensor_model.sv
`timescale 1ns/1ps
`default_nettype none

// Byte-wide SPI master plus BNO085 hub behavior
module sensor_model
    import shtp_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  respond,      // Answer wake pulses and commands
    input  logic  spi_start,
    input  logic  spi_tx_valid,
    input  byte_t spi_tx_data,
    output logic  spi_rx_valid,
    output byte_t spi_rx_data,
    output logic  spi_busy,
    input  logic  cs_n,
    input  logic  ps0_wake,
    output logic  int_n
);

    byte_t out_bytes[$];  // Packets waiting to be read, flat
    int    out_lens[$];
    byte_t cmd_bytes[$];  // Everything written by the host
    int    cmd_lens[$];
    int    resp_sent = 0;

    logic  busy_r = 1'b0, rxv_r = 1'b0, int_r = 1'b1;
    byte_t rxd_r = 8'h00, byte_out = 8'h00;
    logic  cs_q = 1'b1, wake_q = 1'b1, wake_due = 1'b0;
    logic  write_mode = 1'b0, rx_sent = 1'b0;
    int    cur_len = 0, served = 0, cur_cmd_len = 0, wait_cnt = 0;

    assign spi_busy     = busy_r;
    assign spi_rx_valid = rxv_r;
    assign spi_rx_data  = rxd_r;
    assign int_n        = int_r;

    always @(posedge clk) begin
        if (!rst_n) begin
            busy_r <= 1'b0;
            rxv_r  <= 1'b0;
            int_r  <= 1'b1;
            cs_q = 1'b1; wake_q = 1'b1; wake_due = 1'b0;
            write_mode = 1'b0;
            rx_sent    = 1'b0;
            out_bytes.delete();
            out_lens.delete();
        end else begin
            rxv_r <= 1'b0;
            if (wake_q && !ps0_wake && respond) wake_due = 1'b1; // Wake pulse seen
            // ==============================
            // Chip select edges
            // ==============================
            if (cs_q && !cs_n) begin
                served = 0;
                cur_len = 0;
                if (wake_due) begin // Host is writing a command
                    write_mode  = 1'b1;
                    wake_due    = 1'b0;
                    cur_cmd_len = 0;
                end else if (out_lens.size() > 0) begin
                    write_mode = 1'b0;
                    cur_len    = out_lens.pop_front();
                end
            end
            if (!cs_q && cs_n) begin
                if (write_mode) begin
                    cmd_lens.push_back(cur_cmd_len);
                    write_mode = 1'b0;
                    if (respond) begin // Control channel answer, 0xF8 report
                        out_bytes.push_back(8'd5);
                        out_bytes.push_back(8'd0);
                        out_bytes.push_back(CH_CONTROL);
                        out_bytes.push_back(8'd0);
                        out_bytes.push_back(8'hF8);
                        out_lens.push_back(5);
                        resp_sent++;
                    end
                end else begin
                    while (served < cur_len) begin // Drop the rest of an aborted read
                        void'(out_bytes.pop_front());
                        served++;
                    end
                end
            end
            cs_q   = cs_n;
            wake_q = ps0_wake;
            int_r <= !(cs_n && (wake_due || out_lens.size() > 0));
            // ==============================
            // Byte exchange
            // ==============================
            if (!busy_r) begin
                if (spi_start && spi_tx_valid) begin
                    busy_r <= 1'b1;
                    wait_cnt = $urandom % 4; // Random busy length
                    byte_out = 8'h00;
                    if (write_mode) begin
                        cmd_bytes.push_back(spi_tx_data);
                        cur_cmd_len++;
                    end else if (served < cur_len) begin
                        byte_out = out_bytes.pop_front();
                        served++;
                    end
                end
            end else if (wait_cnt > 0) wait_cnt--;
            else if (rx_sent) begin // Busy tail after the rx pulse
                busy_r <= 1'b0;
                rx_sent = 1'b0;
            end else begin
                rxv_r <= 1'b1;
                rxd_r <= byte_out;
                if ($urandom % 2 == 0) rx_sent = 1'b1;
                else busy_r <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bno085_hub.sv
`timescale 1ns/1ps
`default_nettype none

module bno085_hub
    import shtp_pkg::*;
#(
    parameter int unsigned POWERUP_CYCLES = 300_000, // About 100 ms at 3 MHz
    parameter int unsigned WAKE_CYCLES    = 450,
    parameter int unsigned INT_TIMEOUT    = 150_000,
    parameter int unsigned RESP_TIMEOUT   = 300_000,
    parameter int unsigned CMD_GAP_CYCLES = 30_000
) (
    input  logic    clk,
    input  logic    rst_n,
    output logic    spi_start,
    output logic    spi_tx_valid,
    output byte_t   spi_tx_data,
    input  logic    spi_rx_valid,
    input  byte_t   spi_rx_data,
    input  logic    spi_busy,
    output logic    cs_n,
    output logic    ps0_wake,
    input  logic    int_n,
    output logic    quat_valid,
    output sample_t quat_w,
    output sample_t quat_x,
    output sample_t quat_y,
    output sample_t quat_z,
    output logic    gyro_valid,
    output sample_t gyro_x,
    output sample_t gyro_y,
    output sample_t gyro_z,
    output logic    initialized,
    output logic    error
);

    byte_xfer_if xfer ();
    shtp_pkt_if  pkt ();

    logic  pkt_start;
    quat_t quat;
    vec3_t gyro;

    shtp_sequencer #(
        .POWERUP_CYCLES (POWERUP_CYCLES),
        .WAKE_CYCLES    (WAKE_CYCLES),
        .INT_TIMEOUT    (INT_TIMEOUT),
        .RESP_TIMEOUT   (RESP_TIMEOUT),
        .CMD_GAP_CYCLES (CMD_GAP_CYCLES)
    ) u_seq (
        .clk, .rst_n, .int_n, .cs_n, .ps0_wake,
        .xfer, .pkt, .pkt_start, .initialized, .error
    );

    spi_byte_link u_link (
        .clk, .rst_n, .xfer,
        .spi_start, .spi_tx_valid, .spi_tx_data,
        .spi_rx_valid, .spi_busy, .spi_rx_data
    );

    shtp_framer u_framer (.clk, .rst_n, .pkt_start, .xfer, .pkt);

    report_decoder u_dec (.clk, .rst_n, .pkt, .quat, .quat_valid, .gyro, .gyro_valid);

    // Struct fields out to plain ports
    assign quat_w = quat.w;
    assign quat_x = quat.x;
    assign quat_y = quat.y;
    assign quat_z = quat.z;
    assign gyro_x = gyro.x;
    assign gyro_y = gyro.y;
    assign gyro_z = gyro.z;

endmodule

`default_nettype wire

// File: source/shtp_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module shtp_sequencer
    import shtp_pkg::*;
#(
    parameter int unsigned POWERUP_CYCLES = 300_000,
    parameter int unsigned WAKE_CYCLES    = 450,
    parameter int unsigned INT_TIMEOUT    = 150_000,
    parameter int unsigned RESP_TIMEOUT   = 300_000,
    parameter int unsigned CMD_GAP_CYCLES = 30_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        int_n,
    output logic        cs_n,
    output logic        ps0_wake,
    byte_xfer_if.master xfer,
    shtp_pkt_if.reader  pkt,
    output logic        pkt_start,
    output logic        initialized,
    output logic        error
);

    typedef enum logic [3:0] {
        S_POWERUP, S_WAKE, S_WAIT_INT, S_SEND, S_RESP_WAIT,
        S_GAP, S_DATA_WAIT, S_READ, S_ERROR
    } seq_state_t;

    seq_state_t  state;
    cmd_id_t     cmd;
    byte_t       cmd_idx;
    byte_t       rom_data;
    byte_t       rom_len;
    logic [31:0] dly;     // Shared delay and timeout counter
    logic [31:0] limit;
    logic        dly_done;
    logic        int_meta, int_sync;
    logic        is_resp;

    shtp_cmd_rom u_rom (
        .cmd  (cmd),
        .idx  (cmd_idx),
        .data (rom_data),
        .len  (rom_len)
    );

    // Two-flop synchronizer for INT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    always_comb begin
        case (state)
            S_POWERUP:   limit = POWERUP_CYCLES;
            S_WAKE:      limit = WAKE_CYCLES;
            S_WAIT_INT:  limit = INT_TIMEOUT;
            S_RESP_WAIT: limit = RESP_TIMEOUT;
            S_GAP:       limit = CMD_GAP_CYCLES;
            default:     limit = '1;
        endcase
    end

    assign dly_done = (dly + 32'd1) >= limit;
    assign is_resp  = (pkt.channel == CH_CONTROL) && !pkt.hdr_bad;

    // Commands come from the ROM, reads clock out zeros
    assign xfer.req     = (state == S_SEND) || (state == S_READ);
    assign xfer.tx_byte = (state == S_SEND) ? rom_data : 8'h00;

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_POWERUP;
            cmd         <= CMD_PROD_ID;
            cmd_idx     <= 8'd0;
            dly         <= '0;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1; // High selects SPI mode at sensor boot
            pkt_start   <= 1'b0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            pkt_start <= 1'b0;
            case (state)
                S_POWERUP: if (dly_done) begin
                    dly      <= '0;
                    ps0_wake <= 1'b0;
                    state    <= S_WAKE;
                end else dly <= dly + 32'd1;
                S_WAKE: if (dly_done) begin // End of wake pulse
                    dly      <= '0;
                    ps0_wake <= 1'b1;
                    state    <= S_WAIT_INT;
                end else dly <= dly + 32'd1;
                S_WAIT_INT: if (!int_sync) begin
                    cs_n    <= 1'b0;
                    cmd_idx <= 8'd0;
                    state   <= S_SEND;
                end else if (dly_done) begin
                    error <= 1'b1;
                    state <= S_ERROR;
                end else dly <= dly + 32'd1;
                S_SEND: if (xfer.done) begin
                    if (cmd_idx + 8'd1 == rom_len) begin
                        cs_n  <= 1'b1;
                        dly   <= '0;
                        state <= S_RESP_WAIT;
                    end else cmd_idx <= cmd_idx + 8'd1;
                end
                S_RESP_WAIT: if (dly_done) begin
                    error <= 1'b1;
                    state <= S_ERROR;
                end else if (!int_sync) begin
                    cs_n      <= 1'b0;
                    pkt_start <= 1'b1;
                    state     <= S_READ; // Timer holds during the read
                end else dly <= dly + 32'd1;
                S_READ: if (pkt.last) begin
                    cs_n <= 1'b1;
                    if (initialized) state <= S_DATA_WAIT;
                    else if (is_resp) begin
                        dly   <= '0;
                        state <= S_GAP;
                    end else state <= S_RESP_WAIT; // Not ours, keep waiting
                end
                S_GAP: if (dly_done) begin
                    dly <= '0;
                    if (cmd == CMD_EN_GYRO) begin
                        initialized <= 1'b1;
                        state       <= S_DATA_WAIT;
                    end else begin
                        cmd      <= cmd_id_t'(cmd + 2'd1);
                        ps0_wake <= 1'b0;
                        state    <= S_WAKE;
                    end
                end else dly <= dly + 32'd1;
                S_DATA_WAIT: if (!int_sync) begin
                    cs_n      <= 1'b0;
                    pkt_start <= 1'b1;
                    state     <= S_READ;
                end
                S_ERROR: begin // Held until reset
                    cs_n     <= 1'b1;
                    ps0_wake <= 1'b1;
                end
                default: state <= S_ERROR;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/report_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module report_decoder
    import shtp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    shtp_pkt_if.reader pkt,
    output quat_t      quat,
    output logic       quat_valid,
    output vec3_t      gyro,
    output logic       gyro_valid
);

    byte_t   rid;        // Report ID from payload byte 0
    byte_t   lsb;        // Low half of the field in flight
    sample_t sx, sy, sz; // Staged until the report completes
    sample_t word;
    logic    take;

    assign take = pkt.strobe && pkt.in_payload
               && (pkt.channel == CH_REPORTS || pkt.channel == CH_GYRO_RV);
    assign word = {pkt.data, lsb}; // MSB arrives second

    // ==============================
    // Field staging
    // ==============================
    always_ff @(posedge clk) begin
        if (take) begin
            case (pkt.payload_idx)
                8'd0: rid <= pkt.data;
                8'd4, 8'd6, 8'd8, 8'd10: lsb <= pkt.data;
                8'd5: sx <= word;
                8'd7: sy <= word;
                8'd9: sz <= word;
                default: ; // Sequence, status and delay bytes skipped
            endcase
        end
    end

    // ==============================
    // Output commit
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quat       <= '0;
            gyro       <= '0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
            if (take && rid == RID_ROT_VEC && pkt.payload_idx == 8'd11) begin
                quat       <= '{w: word, x: sx, y: sy, z: sz}; // W is the last field
                quat_valid <= 1'b1;
            end
            if (take && rid == RID_GYRO && pkt.payload_idx == 8'd9) begin
                gyro       <= '{x: sx, y: sy, z: word};
                gyro_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/shtp_framer.sv
`timescale 1ns/1ps
`default_nettype none

module shtp_framer
    import shtp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         pkt_start,
    byte_xfer_if.monitor xfer,
    shtp_pkt_if.framer   pkt
);

    logic        active;  // Inside a packet read
    logic [14:0] cnt;     // Bytes already received
    logic [14:0] pkt_len; // Continuation bit dropped
    byte_t       chan;
    logic [14:0] pidx;
    logic        len_bad;

    assign pidx    = cnt - 15'(SHTP_HDR_LEN);
    assign len_bad = (pkt_len <= 15'(SHTP_HDR_LEN)) || (pkt_len > 15'(PKT_LEN_MAX));

    assign pkt.strobe     = active && xfer.done;
    assign pkt.data       = xfer.rx_byte;
    assign pkt.channel    = chan;
    assign pkt.in_payload = (cnt >= 15'(SHTP_HDR_LEN));
    assign pkt.payload_idx = (|pidx[14:PAYLOAD_IDX_W]) ? '1 : pidx[PAYLOAD_IDX_W-1:0];

    // Bad length aborts on the sequence byte
    assign pkt.hdr_bad = pkt.strobe && (cnt == 15'(SHTP_HDR_LEN - 1)) && len_bad;
    assign pkt.last    = pkt.hdr_bad
                       || (pkt.strobe && pkt.in_payload && (cnt + 15'd1 == pkt_len));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (pkt_start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (pkt.strobe) begin
            cnt <= cnt + 15'd1;
            if (pkt.last) active <= 1'b0; // Further done pulses belong to commands
        end
    end

    // Header fields
    always_ff @(posedge clk) begin
        if (pkt.strobe) begin
            case (cnt)
                15'd0: pkt_len[7:0]  <= xfer.rx_byte;
                15'd1: pkt_len[14:8] <= xfer.rx_byte[6:0];
                15'd2: chan          <= xfer.rx_byte;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/spi_byte_link.sv
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link
    import shtp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    byte_xfer_if.link xfer,
    output logic      spi_start,
    output logic      spi_tx_valid,
    output byte_t     spi_tx_data,
    input  logic      spi_rx_valid,
    input  logic      spi_busy,
    input  byte_t     spi_rx_data
);

    typedef enum logic [1:0] {L_IDLE, L_START, L_BUSY} link_state_t;

    link_state_t state;
    logic        rx_seen; // Sticky copy of the master's rx pulse
    logic        launch;

    // No relaunch in the done cycle, req is still the old one there
    assign launch = (state == L_IDLE) && xfer.req && !xfer.done && !spi_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= L_IDLE;
            spi_start    <= 1'b0;
            spi_tx_valid <= 1'b0;
            rx_seen      <= 1'b0;
            xfer.done    <= 1'b0;
        end else begin
            xfer.done <= 1'b0;
            if (spi_rx_valid) rx_seen <= 1'b1;
            case (state)
                L_IDLE: if (launch) begin
                    spi_start    <= 1'b1;
                    spi_tx_valid <= 1'b1;
                    rx_seen      <= 1'b0;
                    state        <= L_START;
                end
                L_START: if (spi_busy) begin // Master took the byte
                    spi_start    <= 1'b0;
                    spi_tx_valid <= 1'b0;
                    state        <= L_BUSY;
                end
                L_BUSY: if ((rx_seen || spi_rx_valid) && !spi_busy) begin
                    xfer.done <= 1'b1;
                    rx_seen   <= 1'b0;
                    state     <= L_IDLE;
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // Byte registers
    always_ff @(posedge clk) begin
        if (launch) spi_tx_data <= xfer.tx_byte;
        if (spi_rx_valid) xfer.rx_byte <= spi_rx_data;
    end

endmodule

`default_nettype wire

// File: source/shtp_cmd_rom.sv
`timescale 1ns/1ps
`default_nettype none

module shtp_cmd_rom
    import shtp_pkg::*;
(
    input  cmd_id_t cmd,
    input  byte_t   idx,
    output byte_t   data,
    output byte_t   len
);

    always_comb begin
        len = (cmd == CMD_PROD_ID) ? CMD_LEN_PROD_ID : CMD_LEN_FEATURE;
    end

    always_comb begin
        data = 8'h00; // Flags, sensitivity and config words stay zero
        if (idx < len) begin
            case (idx)
                8'd0:  data = len;             // Length LSB
                8'd1:  data = 8'h00;           // Length MSB, no continuation
                8'd2:  data = CH_CONTROL;
                8'd3:  data = {6'd0, cmd};     // Sequence number
                8'd4:  data = (cmd == CMD_PROD_ID) ? RID_PROD_ID_REQ : RID_SET_FEATURE;
                8'd5:  data = (cmd == CMD_EN_ROT) ? RID_ROT_VEC : RID_GYRO;
                // Report interval, little-endian
                8'd9:  data = REPORT_INTERVAL_US[7:0];
                8'd10: data = REPORT_INTERVAL_US[15:8];
                8'd11: data = REPORT_INTERVAL_US[23:16];
                8'd12: data = REPORT_INTERVAL_US[31:24];
                default: data = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/shtp_pkt_if.sv
`timescale 1ns/1ps
`default_nettype none

// Received packet bytes with their position, framer to readers
interface shtp_pkt_if
    import shtp_pkg::*;
();
    logic                     strobe;      // One per byte of a read
    byte_t                    data;
    logic                     in_payload;  // Past the 4 byte header
    logic [PAYLOAD_IDX_W-1:0] payload_idx; // Saturates at all ones
    byte_t                    channel;
    logic                     last;        // Final byte, or aborted header
    logic                     hdr_bad;     // Illegal length field

    modport framer (output strobe, data, in_payload, payload_idx, channel, last, hdr_bad);
    modport reader (input strobe, data, in_payload, payload_idx, channel, last, hdr_bad);
endinterface

`default_nettype wire

// File: source/byte_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

// One byte exchange between sequencer and SPI link
interface byte_xfer_if
    import shtp_pkg::*;
();
    logic  req;      // Held until done
    byte_t tx_byte;
    logic  done;     // One-cycle pulse per byte
    byte_t rx_byte;  // Valid with done

    modport master  (output req, tx_byte, input done, rx_byte);
    modport link    (input req, tx_byte, output done, rx_byte);
    modport monitor (input done, rx_byte);
endinterface

`default_nettype wire

// File: source/shtp_pkg.sv
`default_nettype none

package shtp_pkg;

    typedef logic [7:0]         byte_t;
    typedef logic signed [15:0] sample_t;

    // Gyroscope rates, one per axis
    typedef struct packed {
        sample_t x;
        sample_t y;
        sample_t z;
    } vec3_t;

    // Rotation vector, real part first
    typedef struct packed {
        sample_t w;
        sample_t x;
        sample_t y;
        sample_t z;
    } quat_t;

    // Init commands, value doubles as the SHTP sequence number
    typedef enum logic [1:0] {
        CMD_PROD_ID = 2'd0,
        CMD_EN_ROT  = 2'd1,
        CMD_EN_GYRO = 2'd2
    } cmd_id_t;

    localparam int SHTP_HDR_LEN  = 4;     // Length LSB, MSB, channel, sequence
    localparam int PKT_LEN_MAX   = 32766;
    localparam int PAYLOAD_IDX_W = 8;

    localparam byte_t CH_CONTROL = 8'd2;  // SH-2 control
    localparam byte_t CH_REPORTS = 8'd3;  // Non-wake input reports
    localparam byte_t CH_GYRO_RV = 8'd5;  // Gyro rotation vector channel

    localparam byte_t RID_ROT_VEC     = 8'h05;
    localparam byte_t RID_GYRO        = 8'h02; // Calibrated gyroscope
    localparam byte_t RID_PROD_ID_REQ = 8'hF9;
    localparam byte_t RID_SET_FEATURE = 8'hFD;

    localparam logic [31:0] REPORT_INTERVAL_US = 32'd20000; // 50 Hz

    localparam byte_t CMD_LEN_PROD_ID = 8'd5;  // Header plus report ID
    localparam byte_t CMD_LEN_FEATURE = 8'd17; // Header plus 13 byte body

endpackage

`default_nettype wire
